//--- flist.f
+incdir+source
source/input_pkg.sv
source/keypad_event.sv
source/switch_sampler.sv
source/digit_entry.sv
source/input_apb_regs.sv
source/input_top.sv
verif/tb_input_top.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
    --top-module tb_input_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- source/digit_entry.sv
`timescale 1ns/1ps
`include "input_defines.svh"

module digit_entry (
    input  logic                     clk,
    input  logic                     rst_n,
    input  input_pkg::key_event_t    key_evt,
    input  logic                     start,
    input  logic                     uart_complete,
    output input_pkg::entry_status_t entry_stat,
    output logic                     cpu_pause,
    output logic                     overflow
);

    // keypad coordinates, row nibble over column nibble, active low
    localparam input_pkg::key_code_t KEY_0      = 8'b0111_1101;
    localparam input_pkg::key_code_t KEY_1      = 8'b1110_1110;
    localparam input_pkg::key_code_t KEY_2      = 8'b1110_1101;
    localparam input_pkg::key_code_t KEY_3      = 8'b1110_1011;
    localparam input_pkg::key_code_t KEY_4      = 8'b1101_1110;
    localparam input_pkg::key_code_t KEY_5      = 8'b1101_1101;
    localparam input_pkg::key_code_t KEY_6      = 8'b1101_1011;
    localparam input_pkg::key_code_t KEY_7      = 8'b1011_1110;
    localparam input_pkg::key_code_t KEY_8      = 8'b1011_1101;
    localparam input_pkg::key_code_t KEY_9      = 8'b1011_1011;
    localparam input_pkg::key_code_t KEY_BACK   = 8'b0111_1110;  // "*"
    localparam input_pkg::key_code_t KEY_ENTER  = 8'b0111_1011;  // "#"
    localparam input_pkg::key_code_t KEY_PAUSE  = 8'b1110_0111;  // "A"
    localparam input_pkg::key_code_t KEY_TOGGLE = 8'b1101_0111;  // "B"

    localparam input_pkg::digit_count_t MAX_CNT = input_pkg::digit_count_t'(`MAX_DIGITS);
    localparam input_pkg::data_word_t   TEN     = input_pkg::data_word_t'(10);

    input_pkg::entry_state_t state;
    input_pkg::entry_state_t state_nxt;
    input_pkg::data_word_t   value;
    input_pkg::data_word_t   value_nxt;
    input_pkg::digit_count_t count;
    input_pkg::digit_count_t count_nxt;
    logic                    complete;
    logic                    complete_nxt;
    logic                    pause_nxt;
    logic                    is_digit;
    logic [3:0]              digit_val;

    always_comb begin
        is_digit  = 1'b1;
        digit_val = 4'd0;
        case (key_evt.code)
            KEY_0:   digit_val = 4'd0;
            KEY_1:   digit_val = 4'd1;
            KEY_2:   digit_val = 4'd2;
            KEY_3:   digit_val = 4'd3;
            KEY_4:   digit_val = 4'd4;
            KEY_5:   digit_val = 4'd5;
            KEY_6:   digit_val = 4'd6;
            KEY_7:   digit_val = 4'd7;
            KEY_8:   digit_val = 4'd8;
            KEY_9:   digit_val = 4'd9;
            default: is_digit  = 1'b0;  // C, D and the command keys
        endcase
    end

    always_comb begin
        state_nxt    = state;
        value_nxt    = value;
        count_nxt    = count;
        complete_nxt = complete;
        pause_nxt    = cpu_pause;
        case (state)
            input_pkg::ENTRY_IDLE: begin
                if (key_evt.press && key_evt.code == KEY_PAUSE) begin
                    state_nxt = input_pkg::ENTRY_HALT;
                    pause_nxt = 1'b1;
                end else if (start) begin
                    state_nxt    = input_pkg::ENTRY_KEYPAD;
                    value_nxt    = '0;
                    complete_nxt = 1'b0;
                end
            end
            input_pkg::ENTRY_KEYPAD, input_pkg::ENTRY_SWITCH: begin
                if (key_evt.press) begin
                    case (key_evt.code)
                        KEY_ENTER, KEY_PAUSE: begin
                            complete_nxt = 1'b1;
                            count_nxt    = '0;
                            if (key_evt.code == KEY_PAUSE) begin
                                state_nxt = input_pkg::ENTRY_HALT;
                                pause_nxt = 1'b1;
                            end else begin
                                state_nxt = input_pkg::ENTRY_IDLE;
                            end
                        end
                        KEY_TOGGLE: begin
                            state_nxt = (state == input_pkg::ENTRY_KEYPAD) ?
                                        input_pkg::ENTRY_SWITCH : input_pkg::ENTRY_KEYPAD;
                        end
                        KEY_BACK: begin
                            if (state == input_pkg::ENTRY_KEYPAD && count != '0) begin
                                value_nxt = value / TEN;  // drop last digit
                                count_nxt = count - 4'd1;
                            end
                        end
                        default: begin
                            // digits past the limit are dropped
                            if (state == input_pkg::ENTRY_KEYPAD && is_digit && count < MAX_CNT) begin
                                value_nxt = value * TEN + input_pkg::data_word_t'(digit_val);
                                count_nxt = count + 4'd1;
                            end
                        end
                    endcase
                end
            end
            default: begin
                // halted, resume needs the uart to be done
                if (key_evt.press && key_evt.code == KEY_PAUSE && uart_complete) begin
                    state_nxt = input_pkg::ENTRY_IDLE;
                    pause_nxt = 1'b0;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= input_pkg::ENTRY_IDLE;
            value     <= '0;
            count     <= '0;
            complete  <= 1'b0;
            cpu_pause <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            state     <= state_nxt;
            value     <= value_nxt;
            count     <= count_nxt;
            complete  <= complete_nxt;
            cpu_pause <= pause_nxt;
            overflow  <= (count_nxt == MAX_CNT);  // kept in step with count
        end
    end

    always_comb begin
        entry_stat.complete    = complete;
        entry_stat.switch_mode = (state == input_pkg::ENTRY_SWITCH);
        entry_stat.paused      = cpu_pause;
        entry_stat.overflow    = overflow;
        entry_stat.count       = count;
        entry_stat.value       = value;
    end

endmodule

//--- source/input_apb_regs.sv
`timescale 1ns/1ps
`include "input_defines.svh"

module input_apb_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`ADDR_WIDTH-1:0]   paddr,
    input  input_pkg::data_word_t    pwdata,
    output input_pkg::data_word_t    prdata,
    input  input_pkg::entry_status_t entry_stat,
    input  input_pkg::switch_vec_t   switch_val,
    output logic                     start
);

    localparam logic [`ADDR_WIDTH-1:0] ADDR_CTRL   = `ADDR_WIDTH'('h0);
    localparam logic [`ADDR_WIDTH-1:0] ADDR_STATUS = `ADDR_WIDTH'('h4);
    localparam logic [`ADDR_WIDTH-1:0] ADDR_DATA   = `ADDR_WIDTH'('h8);
    localparam logic [`ADDR_WIDTH-1:0] ADDR_SWITCH = `ADDR_WIDTH'('hC);

    input_pkg::entry_status_t stat_q;     // status seen by the bus
    input_pkg::data_word_t    status_word;
    input_pkg::data_word_t    switch_word;
    logic                     ctrl_wr;

    // access phase of a write to CTRL
    assign ctrl_wr = psel && penable && pwrite && (paddr == ADDR_CTRL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stat_q <= '0;
            start  <= 1'b0;
        end else begin
            stat_q <= entry_stat;
            start  <= ctrl_wr && pwdata[0];  // one cycle pulse
        end
    end

    assign status_word = {{(`DATA_WIDTH-8){1'b0}},
                          stat_q.count,
                          stat_q.overflow,
                          stat_q.paused,
                          stat_q.switch_mode,
                          stat_q.complete};

    assign switch_word = {{(`DATA_WIDTH-`SWITCH_CNT){1'b0}}, switch_val};  // zero extended

    // read data straight from the address, no wait states
    always_comb begin
        case (paddr)
            ADDR_STATUS: prdata = status_word;
            ADDR_DATA:   prdata = stat_q.switch_mode ? switch_word : stat_q.value;
            ADDR_SWITCH: prdata = switch_word;
            default:     prdata = '0;  // CTRL and holes read zero
        endcase
    end

endmodule

//--- source/input_defines.svh
`ifndef INPUT_DEFINES_SVH
`define INPUT_DEFINES_SVH

// entered value and APB data width
`define DATA_WIDTH 32

`define SWITCH_CNT 16      // toggle switches on the board

`define MAX_DIGITS 8       // overflow shows from here on

`define STABLE_CYCLES 4    // switch hold time before accept

`define ADDR_WIDTH 4       // APB byte address

`endif

//--- source/input_pkg.sv
`include "input_defines.svh"

package input_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_word_t;   // entered number, APB data
    typedef logic [`SWITCH_CNT-1:0] switch_vec_t;  // switch levels
    typedef logic [7:0]             key_code_t;    // {row, col}, active low, 0 = no key
    typedef logic [3:0]             digit_count_t;

    typedef enum logic [1:0] {
        ENTRY_IDLE   = 2'b00,  // waiting for a start
        ENTRY_SWITCH = 2'b01,  // switches are the source
        ENTRY_KEYPAD = 2'b10,  // digits being typed
        ENTRY_HALT   = 2'b11   // cpu paused
    } entry_state_t;

    typedef struct packed {
        logic      press;  // one cycle per new key
        key_code_t code;
    } key_event_t;

    typedef struct packed {
        logic         complete;
        logic         switch_mode;
        logic         paused;
        logic         overflow;
        digit_count_t count;
        data_word_t   value;
    } entry_status_t;

endpackage

//--- source/input_top.sv
`timescale 1ns/1ps
`include "input_defines.svh"

module input_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  input_pkg::key_code_t   key_coord,
    input  input_pkg::switch_vec_t switch_map,
    input  logic                   uart_complete,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`ADDR_WIDTH-1:0] paddr,
    input  input_pkg::data_word_t  pwdata,
    output input_pkg::data_word_t  prdata,
    output logic                   cpu_pause,
    output logic                   overflow
);

    input_pkg::key_event_t    key_evt;
    input_pkg::entry_status_t entry_stat;
    input_pkg::switch_vec_t   switch_val;
    logic                     start;

    keypad_event u_keypad_event (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_coord (key_coord),
        .key_evt   (key_evt)
    );

    switch_sampler u_switch_sampler (
        .clk        (clk),
        .rst_n      (rst_n),
        .switch_map (switch_map),
        .switch_val (switch_val)
    );

    digit_entry u_digit_entry (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_evt       (key_evt),
        .start         (start),
        .uart_complete (uart_complete),
        .entry_stat    (entry_stat),
        .cpu_pause     (cpu_pause),
        .overflow      (overflow)
    );

    input_apb_regs u_input_apb_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .entry_stat (entry_stat),
        .switch_val (switch_val),
        .start      (start)
    );

endmodule

//--- source/keypad_event.sv
`timescale 1ns/1ps

module keypad_event (
    input  logic                  clk,
    input  logic                  rst_n,
    input  input_pkg::key_code_t  key_coord,
    output input_pkg::key_event_t key_evt
);

    input_pkg::key_code_t sync_q1;
    input_pkg::key_code_t sync_q2;
    input_pkg::key_code_t last_code;  // code seen one cycle earlier
    logic                 new_key;

    // a held key keeps matching last_code, so it fires only once
    assign new_key = (sync_q2 != '0) && (sync_q2 != last_code);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1   <= '0;
            sync_q2   <= '0;
            last_code <= '0;
            key_evt   <= '0;
        end else begin
            sync_q1       <= key_coord;  // keypad is asynchronous
            sync_q2       <= sync_q1;
            last_code     <= sync_q2;    // tracks release too, so a repeat key fires again
            key_evt.press <= new_key;
            key_evt.code  <= sync_q2;
        end
    end

endmodule

//--- source/switch_sampler.sv
`timescale 1ns/1ps
`include "input_defines.svh"

module switch_sampler (
    input  logic                   clk,
    input  logic                   rst_n,
    input  input_pkg::switch_vec_t switch_map,
    output input_pkg::switch_vec_t switch_val
);

    localparam int CNT_W = $clog2(`STABLE_CYCLES + 1);
    localparam logic [CNT_W-1:0] STABLE = CNT_W'(`STABLE_CYCLES);

    input_pkg::switch_vec_t sync_q1;
    input_pkg::switch_vec_t sync_q2;
    input_pkg::switch_vec_t cand;       // value being timed
    logic [CNT_W-1:0]       stable_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1    <= '0;
            sync_q2    <= '0;
            cand       <= '0;
            stable_cnt <= '0;
            switch_val <= '0;
        end else begin
            sync_q1 <= switch_map;
            sync_q2 <= sync_q1;
            if (sync_q2 != cand) begin
                cand       <= sync_q2;
                stable_cnt <= CNT_W'(1);    // first cycle of the new value already seen
            end else if (stable_cnt != STABLE) begin
                stable_cnt <= stable_cnt + CNT_W'(1);
                if (stable_cnt == STABLE - CNT_W'(1)) begin
                    switch_val <= cand;     // held long enough
                end
            end
        end
    end

endmodule

//--- verif/tb_input_top.sv
`timescale 1ns/1ps
`include "input_defines.svh"

module tb_input_top;

    localparam int TIMEOUT_CYCLES = 20000;  // about four times the test length
    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_KEYPAD = 2'd1;
    localparam logic [1:0] S_SWITCH = 2'd2;
    localparam logic [1:0] S_HALT   = 2'd3;
    localparam logic [7:0] DIGIT_KEYS [0:9] = '{8'h7D, 8'hEE, 8'hED, 8'hEB, 8'hDE,
                                                8'hDD, 8'hDB, 8'hBE, 8'hBD, 8'hBB};
    localparam logic [7:0] KEY_BACK   = 8'h7E;  // "*"
    localparam logic [7:0] KEY_ENTER  = 8'h7B;  // "#"
    localparam logic [7:0] KEY_PAUSE  = 8'hE7;  // "A"
    localparam logic [7:0] KEY_TOGGLE = 8'hD7;  // "B"
    localparam logic [3:0] A_CTRL   = 4'h0;
    localparam logic [3:0] A_STATUS = 4'h4;
    localparam logic [3:0] A_DATA   = 4'h8;
    localparam logic [3:0] A_SWITCH = 4'hC;

    logic                    clk;
    logic                    rst_n;
    logic [7:0]              key_coord;
    logic [`SWITCH_CNT-1:0]  switch_map;
    logic                    uart_complete;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`ADDR_WIDTH-1:0]  paddr;
    logic [`DATA_WIDTH-1:0]  pwdata;
    logic [`DATA_WIDTH-1:0]  prdata;
    logic                    cpu_pause;
    logic                    overflow;

    // reference model of the entry FSM
    logic [1:0]  m_state;
    logic [31:0] m_value;
    logic [3:0]  m_count;
    logic        m_complete;
    logic        m_paused;

    logic [31:0] seed;
    int          pass_cnt;
    int          fail_cnt;
    int          err_mark;
    int          cycle_cnt;

    input_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_coord     (key_coord),
        .switch_map    (switch_map),
        .uart_complete (uart_complete),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .cpu_pause     (cpu_pause),
        .overflow      (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] rand_below(input logic [31:0] n);
        return (lcg_next() >> 8) % n;  // low bits of an LCG repeat quickly
    endfunction

    function automatic logic [31:0] exp_status();
        return {24'b0, m_count, m_count == 4'(`MAX_DIGITS), m_paused,
                m_state == S_SWITCH, m_complete};
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act);
        if (act !== exp_v) begin
            $display("Mismatch at %0t: %s expected 0x%08h actual 0x%08h",
                     $time, name, exp_v, act);
            fail_cnt = fail_cnt + 1;
        end else begin
            pass_cnt = pass_cnt + 1;
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        step(1);
        psel    = 1'b1;  // setup cycle
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        step(1);
        penable = 1'b1;
        step(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        step(1);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        step(1);
        penable = 1'b1;
        @(negedge clk);
        data = prdata;   // mid access cycle
        step(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input logic [3:0] addr, input string name, input logic [31:0] exp_v);
        logic [31:0] rd;
        apb_read(addr, rd);
        check(name, exp_v, rd);
    endtask

    task automatic hold_key(input logic [7:0] code);
        key_coord = code;
        step(6);
        key_coord = '0;
        step(6);
    endtask

    task automatic start_entry();
        apb_write(A_CTRL, 32'h1);
        if (m_state == S_IDLE) begin
            m_state    = S_KEYPAD;
            m_value    = '0;
            m_complete = 1'b0;
        end
    endtask

    task automatic press_digit(input logic [3:0] d);
        hold_key(DIGIT_KEYS[d]);
        if (m_state == S_KEYPAD && m_count < 4'(`MAX_DIGITS)) begin
            m_value = m_value * 32'd10 + {28'b0, d};
            m_count = m_count + 4'd1;
        end
    endtask

    task automatic press_cmd(input logic [7:0] code);
        hold_key(code);
        case (m_state)
            S_IDLE: begin
                if (code == KEY_PAUSE) begin
                    m_state  = S_HALT;
                    m_paused = 1'b1;
                end
            end
            S_HALT: begin
                if (code == KEY_PAUSE && uart_complete) begin
                    m_state  = S_IDLE;
                    m_paused = 1'b0;
                end
            end
            default: begin
                if (code == KEY_ENTER || code == KEY_PAUSE) begin
                    m_complete = 1'b1;
                    m_count    = '0;
                    m_paused   = (code == KEY_PAUSE);
                    m_state    = (code == KEY_PAUSE) ? S_HALT : S_IDLE;
                end else if (code == KEY_TOGGLE) begin
                    m_state = (m_state == S_KEYPAD) ? S_SWITCH : S_KEYPAD;
                end else if (code == KEY_BACK && m_state == S_KEYPAD && m_count != 4'd0) begin
                    m_value = m_value / 32'd10;
                    m_count = m_count - 4'd1;
                end
            end
        endcase
    endtask

    task automatic test_done(input string name);
        $display("test %s finished, %0d errors", name, fail_cnt - err_mark);
        err_mark = fail_cnt;
    endtask

    initial begin
        int          n;
        logic [15:0] sw;
        rst_n         = 1'b0;
        key_coord     = '0;
        switch_map    = '0;
        uart_complete = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        m_state       = S_IDLE;
        m_value       = '0;
        m_count       = '0;
        m_complete    = 1'b0;
        m_paused      = 1'b0;
        seed          = 32'h0d067d9a;
        pass_cnt      = 0;
        fail_cnt      = 0;
        err_mark      = 0;
        cycle_cnt     = 0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        step(2);

        check_reg(A_STATUS, "status", 32'h0);
        check_reg(A_DATA, "data", 32'h0);
        check("cpu_pause", 32'h0, {31'b0, cpu_pause});
        check("overflow", 32'h0, {31'b0, overflow});
        test_done("reset");

        for (int i = 0; i < 40; i++) begin
            start_entry();
            n = 1 + int'(rand_below(32'd10));
            for (int j = 0; j < n; j++) begin
                press_digit(4'(rand_below(32'd10)));
            end
            step(4);
            check("overflow", 32'(n >= `MAX_DIGITS), {31'b0, overflow});
            press_cmd(KEY_ENTER);
            step(4);
            check_reg(A_STATUS, "status", exp_status());
            check_reg(A_DATA, "data", m_value);
        end
        test_done("random_entries");

        for (int i = 0; i < 10; i++) begin
            start_entry();
            press_cmd(KEY_BACK);  // count is still zero here
            for (int j = 0; j < 12; j++) begin
                if (rand_below(32'd10) < 32'd4) begin
                    press_cmd(KEY_BACK);
                end else begin
                    press_digit(4'(rand_below(32'd10)));
                end
                if (j == 6) begin
                    step(4);
                    check_reg(A_STATUS, "status", exp_status());
                end
            end
            press_cmd(KEY_ENTER);
            step(4);
            check_reg(A_DATA, "data", m_value);
        end
        test_done("backspace");

        start_entry();
        for (int j = 0; j < 3; j++) begin
            press_digit(4'(rand_below(32'd10)));
        end
        press_cmd(KEY_TOGGLE);
        sw = 16'(rand_below(32'd65536));
        switch_map = sw;
        step(12);
        check_reg(A_STATUS, "status", exp_status());
        check_reg(A_DATA, "data", {16'b0, sw});
        check_reg(A_SWITCH, "switch", {16'b0, sw});
        switch_map = sw ^ 16'(rand_below(32'd65535) + 32'd1);  // short glitch
        step(2);
        switch_map = sw;
        for (int k = 0; k < 4; k++) begin
            check_reg(A_SWITCH, "switch", {16'b0, sw});  // sampled across the whole window
        end
        press_cmd(KEY_TOGGLE);
        step(4);
        check_reg(A_STATUS, "status", exp_status());
        check_reg(A_DATA, "data", m_value);
        press_cmd(KEY_ENTER);
        test_done("switch_mode");

        start_entry();
        press_digit(4'(rand_below(32'd10)));
        press_digit(4'(rand_below(32'd10)));
        press_cmd(KEY_PAUSE);
        step(4);
        check("cpu_pause", 32'h1, {31'b0, cpu_pause});
        check_reg(A_STATUS, "status", exp_status());
        press_cmd(KEY_PAUSE);  // uart still busy
        step(4);
        check("cpu_pause", 32'h1, {31'b0, cpu_pause});
        check_reg(A_STATUS, "status", exp_status());
        uart_complete = 1'b1;
        press_cmd(KEY_PAUSE);
        step(4);
        check("cpu_pause", 32'h0, {31'b0, cpu_pause});
        check_reg(A_STATUS, "status", exp_status());
        check_reg(A_DATA, "data", m_value);
        uart_complete = 1'b0;
        test_done("pause_resume");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
